//--- aluExecute.sv
`timescale 1ns/1ps

module aluExecute import cpuPkg::*; (
	input  logic    clk,
	input  logic    arstN,
	input  logic    decValid,
	input  opcodeT  decOp,
	input  regAddrT decDst,
	input  regAddrT decSrc,
	input  immT     decImm,
	output regAddrT rdAddr1,    // to register file, dst operand
	output regAddrT rdAddr2,    // to register file, src operand
	input  dataT    readData1,
	input  dataT    readData2,
	output logic    exValid,
	output logic    exWrite,    // valid and not a nop
	output regAddrT exDst,
	output dataT    exData,
	output flagsT   exFlags,
	output logic    exFlagsEn   // valid alu operation
);

	dataT opA;                  // dst operand
	dataT opB;                  // src operand
	dataT aluRes;
	logic aluCarry;
	logic isAlu;
	logic [$bits(dataT):0] wide;  // one extra bit for carry or borrow
	logic fwdA;
	logic fwdB;

	assign rdAddr1 = decDst;
	assign rdAddr2 = decSrc;

	// the result in the execute register is not in the register file yet
	assign fwdA = exWrite && (exDst == decDst);
	assign fwdB = exWrite && (exDst == decSrc);
	assign opA  = fwdA ? exData : readData1;
	assign opB  = fwdB ? exData : readData2;

	always_comb begin
		wide     = '0;
		aluRes   = opA;  // nop keeps dst
		aluCarry = 1'b0;
		isAlu    = 1'b1;
		case (decOp)
			OpAdd: begin
				wide     = {1'b0, opA} + {1'b0, opB};
				aluRes   = wide[$bits(dataT)-1:0];
				aluCarry = wide[$bits(dataT)];
			end
			OpSub: begin
				wide     = {1'b0, opA} - {1'b0, opB};
				aluRes   = wide[$bits(dataT)-1:0];
				aluCarry = wide[$bits(dataT)];  // borrow
			end
			OpAnd: aluRes = opA & opB;
			OpOr:  aluRes = opA | opB;
			OpXor: aluRes = opA ^ opB;
			OpShl: begin
				aluRes   = opA << 1;
				aluCarry = opA[$bits(dataT)-1];  // bit shifted out
			end
			OpShr: begin
				aluRes   = opA >> 1;
				aluCarry = opA[0];
			end
			OpMov: begin
				aluRes = opB;
				isAlu  = 1'b0;
			end
			OpLdi: begin
				aluRes = {{($bits(dataT)-$bits(immT)){1'b0}}, decImm};  // zero-extend
				isAlu  = 1'b0;
			end
			default: isAlu = 1'b0;  // nop
		endcase
	end

	// control bits, cleared by reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exValid   <= 1'b0;
			exWrite   <= 1'b0;
			exFlagsEn <= 1'b0;
		end else begin
			exValid   <= decValid;
			exWrite   <= decValid && (decOp != OpNop);
			exFlagsEn <= decValid && isAlu;
		end
	end

	// result payload
	always_ff @(posedge clk) begin
		if (decValid) begin
			exDst              <= decDst;
			exData             <= aluRes;
			exFlags[FlagZero]  <= (aluRes == '0);
			exFlags[FlagCarry] <= aluCarry;
			exFlags[FlagNeg]   <= aluRes[$bits(dataT)-1];
		end
	end

endmodule

//--- cpuPkg.sv
package cpuPkg;

	// datapath widths, fixed by the 16-bit instruction encoding
	typedef logic [15:0] dataT;     // register and alu value
	typedef logic [3:0]  regAddrT;  // register index, sixteen entries
	typedef logic [3:0]  opcodeT;   // operation field
	typedef logic [7:0]  immT;      // ldi immediate, zero-extended on use
	typedef logic [2:0]  flagsT;    // {zero, carry, negative}

	// bit positions inside flagsT
	localparam int FlagZero  = 2;
	localparam int FlagCarry = 1;
	localparam int FlagNeg   = 0;

	// instruction word layout
	//   [15:12] opcode
	//   [11:8]  dst
	//   [7:4]   src
	//   [7:0]   immediate, ldi only (overlaps src)

	// opcode values, dst = dst op src
	localparam opcodeT OpNop = 4'h0;  // no write, no flag change
	localparam opcodeT OpAdd = 4'h1;  // carry out of bit 15
	localparam opcodeT OpSub = 4'h2;  // carry is borrow
	localparam opcodeT OpAnd = 4'h3;  // carry cleared
	localparam opcodeT OpOr  = 4'h4;  // carry cleared
	localparam opcodeT OpXor = 4'h5;  // carry cleared
	localparam opcodeT OpShl = 4'h6;  // shift dst left by one, msb to carry
	localparam opcodeT OpShr = 4'h7;  // shift dst right by one, lsb to carry
	localparam opcodeT OpMov = 4'h8;  // dst = src, flags kept
	localparam opcodeT OpLdi = 4'h9;  // dst = {8'h00, imm}, flags kept

	// 4'ha .. 4'hf are not defined
	// decode maps them onto OpNop

	// flag update rule
	// only the seven alu operations touch the flag register
	// mov, ldi and nop leave it alone

endpackage

//--- datapathCore.f
cpuPkg.sv
instrDecode.sv
registerFile.sv
aluExecute.sv
resultWriteback.sv
datapathCore.sv
datapathCore_props.sv
datapathCore_tb.sv

//--- datapathCore.sv
`timescale 1ns/1ps

module datapathCore import cpuPkg::*; (
	input  logic    clk,
	input  logic    arstN,
	input  logic    instrValid,
	input  dataT    instr,
	output logic    wbEn,
	output regAddrT wbAddr,
	output dataT    wbData,
	output flagsT   flags
);

	// decode to execute
	logic    decValid;
	opcodeT  decOp;
	regAddrT decDst;
	regAddrT decSrc;
	immT     decImm;

	// execute and register file read ports
	regAddrT rdAddr1;
	regAddrT rdAddr2;
	dataT    readData1;
	dataT    readData2;

	// execute to result
	logic    exValid;
	logic    exWrite;
	regAddrT exDst;
	dataT    exData;
	flagsT   exFlags;
	logic    exFlagsEn;

	// result to register file write port
	logic    writeEn;
	regAddrT wrAddr;
	dataT    writeData;

	instrDecode u_instrDecode (
		.clk(clk), .arstN(arstN),
		.instrValid(instrValid), .instr(instr),
		.decValid(decValid), .decOp(decOp),
		.decDst(decDst), .decSrc(decSrc), .decImm(decImm)
	);

	aluExecute u_aluExecute (
		.clk(clk), .arstN(arstN),
		.decValid(decValid), .decOp(decOp),
		.decDst(decDst), .decSrc(decSrc), .decImm(decImm),
		.rdAddr1(rdAddr1), .rdAddr2(rdAddr2),
		.readData1(readData1), .readData2(readData2),
		.exValid(exValid), .exWrite(exWrite), .exDst(exDst),
		.exData(exData), .exFlags(exFlags), .exFlagsEn(exFlagsEn)
	);

	registerFile u_registerFile (
		.clk(clk), .arstN(arstN),
		.writeEn(writeEn), .writeData(writeData),
		.srcAddr(rdAddr2), .dstAddr(rdAddr1),  // port 1 reads dst, port 2 reads src
		.readData1(readData1), .readData2(readData2),
		.wrAddr(wrAddr)
	);

	resultWriteback u_resultWriteback (
		.clk(clk), .arstN(arstN),
		.exValid(exValid), .exWrite(exWrite), .exDst(exDst),
		.exData(exData), .exFlags(exFlags), .exFlagsEn(exFlagsEn),
		.writeEn(writeEn), .wrAddr(wrAddr), .writeData(writeData),
		.wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData), .flags(flags)
	);

endmodule

//--- datapathCore_props.sv
`timescale 1ns/1ps

module datapathCoreProps import cpuPkg::*; (
	input logic  clk,
	input logic  arstN,
	input logic  instrValid,
	input dataT  instr,
	input logic  wbEn,
	input flagsT flags
);

	opcodeT inOp;
	logic   acceptWr;   // strobe carrying a register write
	logic   acceptAlu;  // strobe carrying a flag-setting operation

	assign inOp      = instr[15:12];
	assign acceptWr  = instrValid && (inOp != OpNop) && (inOp <= OpLdi);
	assign acceptAlu = instrValid && (inOp >= OpAdd) && (inOp <= OpShr);

	// report visible two edges after accept, so it is sampled at the third
	wbTiming: assert property (@(posedge clk) disable iff (!arstN)
		wbEn == $past(acceptWr, 3))
		else $error("wbEn does not match an accepted write two cycles earlier");

	wbInReset: assert property (@(posedge clk)
		!arstN |-> !wbEn)
		else $error("wbEn high while reset is asserted");

	// mov, ldi, nop and idle cycles keep the flags
	flagsHeld: assert property (@(posedge clk) disable iff (!arstN)
		!$past(acceptAlu, 3) |-> $stable(flags))
		else $error("flags changed without an alu write-back");

endmodule

bind datapathCore datapathCoreProps u_props (.*);

//--- datapathCore_tb.sv
`timescale 1ns/1ps

module datapathCore_tb import cpuPkg::*; ();

	localparam int RandCycles    = 300;                  // cycles per random phase
	localparam int TotalCycles   = 2 * RandCycles + 120;  // random, directed, resets, drains
	localparam int TimeoutCycles = TotalCycles + 50;
	localparam int ClkPeriod     = 4;                     // ns

	logic    clk;
	logic    arstN;
	logic    instrValid;
	dataT    instr;
	logic    wbEn;
	regAddrT wbAddr;
	dataT    wbData;
	flagsT   flags;

	// reference model state
	dataT  modelRegs [16];
	flagsT modelFlags;

	// expected write-backs, oldest first
	regAddrT expAddr  [$];
	dataT    expData  [$];
	flagsT   expFlags [$];
	int      expEdge  [$];  // edge count at which the report must be visible

	int edgeCount = 0;
	int wbIndex   = 0;
	int dataErrs  = 0;
	int addrErrs  = 0;
	int flagErrs  = 0;
	int otherErrs = 0;

	datapathCore u_datapathCore (
		.clk(clk), .arstN(arstN),
		.instrValid(instrValid), .instr(instr),
		.wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData), .flags(flags)
	);

	initial clk = 1'b0;
	always #(ClkPeriod / 2) clk = ~clk;

	always @(posedge clk) edgeCount <= edgeCount + 1;

	task automatic checkData(input string name, input dataT exp, input dataT act);
		if (exp !== act) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			dataErrs++;
		end
	endtask

	task automatic checkAddr(input string name, input regAddrT exp, input regAddrT act);
		if (exp !== act) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			addrErrs++;
		end
	endtask

	task automatic checkFlags(input string name, input flagsT exp, input flagsT act);
		if (exp !== act) begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			flagErrs++;
		end
	endtask

	// executes one instruction on the model, queues its write-back if any
	function automatic void modelExec(input dataT ins, input int dueEdge);
		opcodeT          op;
		regAddrT         d;
		regAddrT         s;
		dataT            a;
		dataT            b;
		dataT            res;
		logic [16:0]     wide;
		logic            c;
		logic            alu;
		op   = ins[15:12];
		d    = ins[11:8];
		s    = ins[7:4];
		a    = modelRegs[d];
		b    = modelRegs[s];
		c    = 1'b0;
		alu  = 1'b1;
		wide = '0;
		case (op)
			OpAdd: begin
				wide = {1'b0, a} + {1'b0, b};
				res  = wide[15:0];
				c    = wide[16];
			end
			OpSub: begin
				wide = {1'b0, a} - {1'b0, b};
				res  = wide[15:0];
				c    = wide[16];  // borrow
			end
			OpAnd: res = a & b;
			OpOr:  res = a | b;
			OpXor: res = a ^ b;
			OpShl: begin
				res = {a[14:0], 1'b0};
				c   = a[15];
			end
			OpShr: begin
				res = {1'b0, a[15:1]};
				c   = a[0];
			end
			OpMov: begin
				res = b;
				alu = 1'b0;
			end
			OpLdi: begin
				res = {8'h00, ins[7:0]};
				alu = 1'b0;
			end
			default: return;  // nop and undefined opcodes write nothing
		endcase
		if (alu) begin
			modelFlags = {res == 16'h0000, c, res[15]};
		end
		modelRegs[d] = res;
		expAddr.push_back(d);
		expData.push_back(res);
		expFlags.push_back(modelFlags);
		expEdge.push_back(dueEdge);
	endfunction

	function automatic void modelClear();
		for (int i = 0; i < 16; i++) begin
			modelRegs[i] = '0;
		end
		modelFlags = '0;
		expAddr.delete();
		expData.delete();
		expFlags.delete();
		expEdge.delete();
	endfunction

	// few registers most of the time, so results get reused right away
	function automatic dataT randInstr();
		logic [31:0] r;
		logic [31:0] sel;
		opcodeT      op;
		regAddrT     d;
		regAddrT     s;
		r   = $urandom;
		sel = $urandom % 11;
		op  = (sel == 10) ? 4'hc : sel[3:0];  // 4'hc is undefined
		d   = (r[20:18] == 3'd0) ? r[11:8] : {2'b00, r[1:0]};
		s   = (r[23:21] == 3'd0) ? r[15:12] : {2'b00, r[3:2]};
		if (op == OpLdi) begin
			return {op, d, r[31:24]};
		end
		return {op, d, s, r[27:24]};
	endfunction

	// drive on the edge, the dut takes it at the next one
	task automatic issue(input dataT ins);
		@(posedge clk);
		instrValid <= 1'b1;
		instr      <= ins;
		modelExec(ins, edgeCount + 4);  // edgeCount still holds the previous edge here
	endtask

	task automatic idle();
		logic [31:0] r;
		r = $urandom;
		@(posedge clk);
		instrValid <= 1'b0;
		instr      <= r[15:0];  // garbage, must be ignored
	endtask

	task automatic drain();
		idle();
		while (expAddr.size() != 0) begin
			@(posedge clk);
		end
		repeat (3) @(posedge clk);
	endtask

	task automatic applyReset();
		@(posedge clk);
		arstN      <= 1'b0;
		instrValid <= 1'b0;
		repeat (8) @(posedge clk);
		modelClear();
		@(negedge clk);
		checkFlags("flags in reset", '0, flags);
		@(posedge clk);
		arstN <= 1'b1;
	endtask

	task automatic randomPhase();
		repeat (RandCycles) begin
			if ($urandom % 5 == 0) begin
				idle();
			end else begin
				issue(randInstr());
			end
		end
	endtask

	// write-back monitor, outputs are settled at the falling edge
	always @(negedge clk) begin
		if (arstN && wbEn) begin
			if (expAddr.size() == 0) begin
				$display("unexpected write-back to register %h with data %h", wbAddr, wbData);
				otherErrs++;
			end else begin
				checkAddr($sformatf("wb %0d addr", wbIndex), expAddr.pop_front(), wbAddr);
				checkData($sformatf("wb %0d data", wbIndex), expData.pop_front(), wbData);
				checkFlags($sformatf("wb %0d flags", wbIndex), expFlags.pop_front(), flags);
				if (expEdge[0] != edgeCount) begin
					$display("write-back %0d showed up at edge %0d instead of edge %0d",
						wbIndex, edgeCount, expEdge[0]);
					otherErrs++;
				end
				void'(expEdge.pop_front());
			end
			wbIndex++;
		end
	end

	initial begin
		#(TimeoutCycles * ClkPeriod);
		$display("timeout: run did not finish within %0d cycles", TimeoutCycles);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		void'($urandom(32'hc7b4));
		arstN      = 1'b0;
		instrValid = 1'b0;
		instr      = '0;
		modelClear();
		repeat (8) @(posedge clk);
		arstN <= 1'b1;

		// cleared file: immediate lands, untouched r5 reads 0
		issue(16'h91a5);  // ldi r1, 0xa5
		issue(16'h8250);  // mov r2, r5
		drain();

		// dependent chain, forwarded and then with a gap
		issue(16'h93f0);  // ldi r3, 0xf0
		issue(16'h6300);  // shl r3
		issue(16'h1330);  // add r3, r3
		idle();
		issue(16'h2430);  // sub r4, r3
		idle();
		issue(16'h5340);  // xor r3, r4
		issue(16'h7300);  // shr r3
		drain();

		randomPhase();

		// reset in mid-stream, then read every register back
		applyReset();
		for (int i = 0; i < 16; i++) begin
			issue({OpMov, i[3:0], i[3:0], 4'h0});
		end
		drain();

		randomPhase();
		drain();

		$display("errors: data %0d, addr %0d, flags %0d, other %0d",
			dataErrs, addrErrs, flagErrs, otherErrs);
		if (dataErrs + addrErrs + flagErrs + otherErrs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- instrDecode.sv
`timescale 1ns/1ps

module instrDecode import cpuPkg::*; (
	input  logic    clk,
	input  logic    arstN,
	input  logic    instrValid,  // one instruction per strobe
	input  dataT    instr,
	output logic    decValid,
	output opcodeT  decOp,
	output regAddrT decDst,
	output regAddrT decSrc,
	output immT     decImm
);

	opcodeT  rawOp;     // opcode field as it arrives
	opcodeT  legalOp;   // after illegal-opcode filtering
	regAddrT rawDst;
	regAddrT rawSrc;
	immT     rawImm;

	// field split
	assign rawOp  = instr[15:12];
	assign rawDst = instr[11:8];
	assign rawSrc = instr[7:4];
	assign rawImm = instr[7:0];  // shares bits with src

	// anything outside the defined set becomes a nop
	// so execute only ever sees legal operations
	always_comb begin
		case (rawOp)
			OpAdd,
			OpSub,
			OpAnd,
			OpOr,
			OpXor,
			OpShl,
			OpShr,
			OpMov,
			OpLdi:   legalOp = rawOp;
			default: legalOp = OpNop;  // includes OpNop itself
		endcase
	end

	// valid bit, one cycle behind the strobe
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			decValid <= 1'b0;
		end else begin
			decValid <= instrValid;
		end
	end

	// instruction fields, captured only on a strobe
	always_ff @(posedge clk) begin
		if (instrValid) begin
			decOp  <= legalOp;
			decDst <= rawDst;
			decSrc <= rawSrc;
			decImm <= rawImm;
		end
	end

	// fields hold their last value while idle
	// decValid low keeps execute from acting on them

endmodule

//--- registerFile.sv
`timescale 1ns/1ps

module registerFile import cpuPkg::*; (
	input  logic    clk,
	input  logic    arstN,
	input  logic    writeEn,
	input  dataT    writeData,
	input  regAddrT srcAddr,    // read port 2 address
	input  regAddrT dstAddr,    // read port 1 address
	output dataT    readData1,  // value of dstAddr
	output dataT    readData2,  // value of srcAddr
	input  regAddrT wrAddr      // write address, from the result stage
);

	localparam int NumRegs = 16;

	dataT regs [NumRegs];

	// write port
	// reset clears every entry, so a never-written register reads 0
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[wrAddr] <= writeData;
		end
	end

	// read ports, combinational
	// no write-through here
	// execute covers the one-cycle gap by forwarding from its own register
	assign readData1 = regs[dstAddr];
	assign readData2 = regs[srcAddr];

	// the write address is separate from the read addresses
	// reads belong to the instruction in decode, the write to the one in result
	//
	// timing seen from the pipeline
	//   edge N   instruction enters decode
	//   edge N+1 result captured in execute
	//   edge N+2 entry written here
	// an instruction decoded after N+2 reads the new value straight from regs
	//
	// entry 0 is an ordinary register
	// it is writable and has no hardwired zero

endmodule

//--- resultWriteback.sv
`timescale 1ns/1ps

module resultWriteback import cpuPkg::*; (
	input  logic    clk,
	input  logic    arstN,
	input  logic    exValid,
	input  logic    exWrite,
	input  regAddrT exDst,
	input  dataT    exData,
	input  flagsT   exFlags,
	input  logic    exFlagsEn,
	output logic    writeEn,    // register file write strobe
	output regAddrT wrAddr,
	output dataT    writeData,
	output logic    wbEn,       // one pulse per committed write
	output regAddrT wbAddr,
	output dataT    wbData,
	output flagsT   flags       // architectural status flags
);

	logic commit;       // a real register write this cycle
	logic flagUpdate;   // an alu operation retires this cycle

	// straight pass to the register file
	// the write lands on the same edge as the report below
	assign writeEn   = exWrite;
	assign wrAddr    = exDst;
	assign writeData = exData;

	assign commit     = exValid && exWrite;
	assign flagUpdate = exValid && exFlagsEn;

	// control state
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wbEn  <= 1'b0;
			flags <= '0;
		end else begin
			wbEn <= commit;
			if (flagUpdate) begin
				flags <= exFlags;  // mov, ldi and nop keep the old flags
			end
		end
	end

	// write-back report
	// only meaningful while wbEn is high
	always_ff @(posedge clk) begin
		if (commit) begin
			wbAddr <= exDst;
			wbData <= exData;
		end
	end

	// after edge N+2 the top ports show wbEn, wbAddr, wbData
	// and the register file already holds wbData at wbAddr

endmodule

//--- run.sh
#!/bin/sh
# build and run the datapathCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module datapathCore_tb \
	-f datapathCore.f \
	-o datapathCore_sim \
	&& ./obj_dir/datapathCore_sim | grep -qx "TEST PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
